/* source/acc_cfg_pkg.sv */
////////////////////////////////////////////////////////////
// Sizes, run configuration and host bus types shared by the
// accelerator RTL and testbench
////////////////////////////////////////////////////////////
`default_nettype none

package acc_cfg_pkg;

    // Datapath sizes
    localparam int BUS_W        = 32;
    localparam int PIX_W        = 8;
    localparam int BUS_LANES    = BUS_W / PIX_W;
    localparam int NUM_CH       = 4;
    localparam int FILT_X       = 3;
    localparam int FILT_Y       = 3;
    localparam int SHIFT_W      = 3;
    localparam int ACC_W        = 20;

    // Four signed weights per bus word, 36 in total
    localparam int WEIGHT_WORDS = 9;
    localparam int WT_IDX_W     = $clog2(WEIGHT_WORDS);

    // Activation memory and map geometry
    localparam int ACT_BYTES    = 1024;
    localparam int ADDR_W       = 10;
    localparam int WORD_W       = ADDR_W - 2;
    localparam int MAX_DIM      = 16;
    localparam int DIM_W        = 5;
    localparam int POS_W        = $clog2(MAX_DIM);

    // Input map size, dimx times dimy a multiple of 4
    typedef struct packed {
        logic [DIM_W-1:0] ifmap_dimx;
        logic [DIM_W-1:0] ifmap_dimy;
    } acc_cfg_t;

    typedef struct packed {
        logic             valid;
        logic             wen;
        logic [BUS_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic             rvalid;
        logic [BUS_W-1:0] rdata;
    } bus_rsp_t;

endpackage

`default_nettype wire

/* source/acc_ctrl_pkg.sv */
////////////////////////////////////////////////////////////
// Controller states and the internal strobe bundles driven
// into the activation buffer and the MAC array
////////////////////////////////////////////////////////////
`default_nettype none

package acc_ctrl_pkg;

    typedef enum logic [2:0] {
        S_IDLE        = 3'd0,
        S_LOADWEIGHTS = 3'd1,
        S_LOADSHIFT   = 3'd2,
        S_LOADACTS    = 3'd3,
        S_COMPUTE     = 3'd4,
        S_READACTS    = 3'd5
    } ctrl_state_t;

    // Activation buffer port controls
    typedef struct packed {
        logic                           rd_en;
        logic [acc_cfg_pkg::ADDR_W-1:0] rd_addr;
        logic                           wr_en;
        logic [acc_cfg_pkg::ADDR_W-1:0] wr_addr;
        logic [acc_cfg_pkg::BUS_W-1:0]  wr_data;
    } buf_ctrl_t;

    // Weight and shift register loads
    typedef struct packed {
        logic                             wt_wr_en;
        logic [acc_cfg_pkg::WT_IDX_W-1:0] wt_index;
        logic                             shift_wr_en;
        logic [acc_cfg_pkg::BUS_W-1:0]    data;
    } mac_load_t;

    // Marks a filter row arriving on the buffer read data
    typedef struct packed {
        logic       row_valid;
        logic       row_last;
        logic [1:0] row_sel;
    } row_strobe_t;

endpackage

`default_nettype wire

/* source/act_buffer.sv */
////////////////////////////////////////////////////////////
// Byte-wide activation memory, four-byte reads a cycle late
////////////////////////////////////////////////////////////
`default_nettype none

module act_buffer (
    input  logic                          clk,
    input  logic                          nrst,
    input  acc_ctrl_pkg::buf_ctrl_t       buf_i,
    output logic [acc_cfg_pkg::BUS_W-1:0] rd_data_o
);

    logic [acc_cfg_pkg::PIX_W-1:0] mem [acc_cfg_pkg::ACT_BYTES];
    logic [acc_cfg_pkg::BUS_W-1:0] rd_data_q;

    // Lane b of the word goes to byte addr+b
    always_ff @(posedge clk) begin : memWrite
        if (buf_i.wr_en) begin
            for (int b = 0; b < acc_cfg_pkg::BUS_LANES; b++) begin
                mem[buf_i.wr_addr + acc_cfg_pkg::ADDR_W'(b)]
                    <= buf_i.wr_data[acc_cfg_pkg::PIX_W*b +: acc_cfg_pkg::PIX_W];
            end
        end
    end

    // Unaligned read, addresses wrap at the top of memory
    always_ff @(posedge clk or negedge nrst) begin : memRead
        if (!nrst) begin
            rd_data_q <= '0;
        end else if (buf_i.rd_en) begin
            for (int b = 0; b < acc_cfg_pkg::BUS_LANES; b++) begin
                rd_data_q[acc_cfg_pkg::PIX_W*b +: acc_cfg_pkg::PIX_W]
                    <= mem[buf_i.rd_addr + acc_cfg_pkg::ADDR_W'(b)];
            end
        end
    end

    assign rd_data_o = rd_data_q;

endmodule

`default_nettype wire

/* source/mac_array.sv */
////////////////////////////////////////////////////////////
// Four-channel 3x3 dot product with per-channel shift and a
// 0..255 clamp, one packed output word per window
////////////////////////////////////////////////////////////
`default_nettype none

module mac_array (
    input  logic                          clk,
    input  logic                          nrst,
    input  acc_ctrl_pkg::mac_load_t       load_i,
    input  acc_ctrl_pkg::row_strobe_t     row_i,
    input  logic [acc_cfg_pkg::BUS_W-1:0] row_data_i,
    output logic                          out_valid_o,
    output logic [acc_cfg_pkg::BUS_W-1:0] out_word_o
);

    // Weight i sits in word i/4, lane i%4
    logic [acc_cfg_pkg::BUS_W-1:0]                    wt_words [acc_cfg_pkg::WEIGHT_WORDS];
    logic [acc_cfg_pkg::SHIFT_W-1:0]                  shift_q  [acc_cfg_pkg::NUM_CH];
    logic [acc_cfg_pkg::FILT_X*acc_cfg_pkg::PIX_W-1:0] win_q   [acc_cfg_pkg::FILT_Y];
    logic [acc_cfg_pkg::FILT_X*acc_cfg_pkg::PIX_W-1:0] cur_win [acc_cfg_pkg::FILT_Y];

    logic signed [acc_cfg_pkg::ACC_W-1:0] sum_d [acc_cfg_pkg::NUM_CH];
    logic signed [acc_cfg_pkg::ACC_W-1:0] sum_q [acc_cfg_pkg::NUM_CH];
    logic                                 sum_valid_q;
    logic [acc_cfg_pkg::BUS_W-1:0]        word_d;
    logic [acc_cfg_pkg::BUS_W-1:0]        out_word_q;
    logic                                 out_valid_q;

    // Last row is taken straight off the read data
    always_comb begin : windowView
        cur_win = win_q;
        cur_win[row_i.row_sel] = row_data_i[acc_cfg_pkg::FILT_X*acc_cfg_pkg::PIX_W-1:0];
    end

    always_comb begin : dotProducts
        int                              widx;
        logic [acc_cfg_pkg::PIX_W-1:0]   pix;
        logic signed [acc_cfg_pkg::PIX_W-1:0] wt;
        for (int c = 0; c < acc_cfg_pkg::NUM_CH; c++) begin
            sum_d[c] = '0;
            for (int r = 0; r < acc_cfg_pkg::FILT_Y; r++) begin
                for (int x = 0; x < acc_cfg_pkg::FILT_X; x++) begin
                    widx = (c * acc_cfg_pkg::FILT_Y + r) * acc_cfg_pkg::FILT_X + x;
                    pix  = cur_win[r][acc_cfg_pkg::PIX_W*x +: acc_cfg_pkg::PIX_W];
                    wt   = wt_words[widx / acc_cfg_pkg::BUS_LANES]
                               [acc_cfg_pkg::PIX_W*(widx % acc_cfg_pkg::BUS_LANES)
                                +: acc_cfg_pkg::PIX_W];
                    // Unsigned pixel times signed weight
                    sum_d[c] = sum_d[c]
                             + acc_cfg_pkg::ACC_W'($signed({1'b0, pix}) * wt);
                end
            end
        end
    end

    always_comb begin : shiftClamp
        logic signed [acc_cfg_pkg::ACC_W-1:0] shifted;
        for (int c = 0; c < acc_cfg_pkg::NUM_CH; c++) begin
            shifted = sum_q[c] >>> shift_q[c];
            if (shifted < 0) begin
                word_d[acc_cfg_pkg::PIX_W*c +: acc_cfg_pkg::PIX_W] = '0;
            end else if (shifted > 255) begin
                word_d[acc_cfg_pkg::PIX_W*c +: acc_cfg_pkg::PIX_W] = '1;
            end else begin
                word_d[acc_cfg_pkg::PIX_W*c +: acc_cfg_pkg::PIX_W] =
                    shifted[acc_cfg_pkg::PIX_W-1:0];
            end
        end
    end

    always_ff @(posedge clk) begin : dataRegs
        if (load_i.wt_wr_en) wt_words[load_i.wt_index] <= load_i.data;
        if (load_i.shift_wr_en) begin
            for (int c = 0; c < acc_cfg_pkg::NUM_CH; c++) begin
                shift_q[c] <= load_i.data[acc_cfg_pkg::PIX_W*c +: acc_cfg_pkg::SHIFT_W];
            end
        end
        if (row_i.row_valid) begin
            win_q[row_i.row_sel] <= row_data_i[acc_cfg_pkg::FILT_X*acc_cfg_pkg::PIX_W-1:0];
        end
        if (row_i.row_valid && row_i.row_last) sum_q <= sum_d;
        if (sum_valid_q) out_word_q <= word_d;
    end

    // Two pipeline stages after the last row arrives
    always_ff @(posedge clk or negedge nrst) begin : validPipe
        if (!nrst) begin
            sum_valid_q <= 1'b0;
            out_valid_q <= 1'b0;
        end else begin
            sum_valid_q <= row_i.row_valid && row_i.row_last;
            out_valid_q <= sum_valid_q;
        end
    end

    assign out_valid_o = out_valid_q;
    assign out_word_o  = out_word_q;

endmodule

`default_nettype wire

/* source/acc_controller.sv */
////////////////////////////////////////////////////////////
// Run sequencer: loads weights, shifts and the input map,
// walks the 3x3 window and streams the output map back out
////////////////////////////////////////////////////////////
`default_nettype none

module acc_controller (
    input  logic                                clk,
    input  logic                                nrst,
    input  acc_cfg_pkg::acc_cfg_t               cfg_i,
    input  logic                                start_i,
    input  logic                                clear_i,
    input  acc_cfg_pkg::bus_req_t               bus_req_i,
    output logic                                bus_ready_o,
    output acc_cfg_pkg::bus_rsp_t               bus_rsp_o,
    output logic                                busy_o,
    output logic                                done_o,
    output acc_ctrl_pkg::buf_ctrl_t             buf_o,
    input  logic [acc_cfg_pkg::BUS_W-1:0]       buf_rd_data_i,
    output acc_ctrl_pkg::mac_load_t             mac_load_o,
    output acc_ctrl_pkg::row_strobe_t           row_o,
    input  logic                                mac_out_valid_i,
    input  logic [acc_cfg_pkg::BUS_W-1:0]       mac_out_word_i
);

    acc_ctrl_pkg::ctrl_state_t state_q;
    acc_ctrl_pkg::ctrl_state_t state_d;

    // Bus handshake
    logic load_state;
    logic bus_hs;
    logic data_write;
    logic data_read;
    logic last_read;

    // Map geometry
    logic [acc_cfg_pkg::ADDR_W-1:0] map_size;
    logic [acc_cfg_pkg::DIM_W-1:0]  out_dimx;
    logic [acc_cfg_pkg::DIM_W-1:0]  out_dimy;
    logic [acc_cfg_pkg::WORD_W-1:0] num_opix;

    // Load pointers
    logic [acc_cfg_pkg::WT_IDX_W-1:0] wt_ptr;
    logic [acc_cfg_pkg::ADDR_W-1:0]   wr_ptr;

    // Window walk
    logic [1:0]                      fy;
    logic [acc_cfg_pkg::POS_W-1:0]   ox;
    logic [acc_cfg_pkg::POS_W-1:0]   oy;
    logic                            issue;
    logic                            issue_done;
    logic [acc_cfg_pkg::ADDR_W-1:0]  row_base;
    logic [acc_cfg_pkg::ADDR_W-1:0]  row_addr;

    // Writeback and readout
    logic [acc_cfg_pkg::WORD_W-1:0]  wb_cnt;
    logic [acc_cfg_pkg::WORD_W-1:0]  rd_cnt;
    logic [acc_cfg_pkg::ADDR_W-1:0]  wb_addr;
    logic [acc_cfg_pkg::ADDR_W-1:0]  rd_addr;
    acc_ctrl_pkg::row_strobe_t       row_q;
    logic                            rvalid_q;
    logic                            done_q;

    assign map_size = acc_cfg_pkg::ADDR_W'(cfg_i.ifmap_dimx)
                    * acc_cfg_pkg::ADDR_W'(cfg_i.ifmap_dimy);
    assign out_dimx = cfg_i.ifmap_dimx - acc_cfg_pkg::DIM_W'(2);
    assign out_dimy = cfg_i.ifmap_dimy - acc_cfg_pkg::DIM_W'(2);
    assign num_opix = acc_cfg_pkg::WORD_W'(out_dimx) * acc_cfg_pkg::WORD_W'(out_dimy);

    // Writes accepted while loading, reads only during readout
    assign load_state = state_q inside {acc_ctrl_pkg::S_LOADWEIGHTS,
                                        acc_ctrl_pkg::S_LOADSHIFT,
                                        acc_ctrl_pkg::S_LOADACTS};
    assign bus_ready_o = (load_state && bus_req_i.wen)
                       || (state_q == acc_ctrl_pkg::S_READACTS && !bus_req_i.wen);
    assign bus_hs     = bus_req_i.valid && bus_ready_o;
    assign data_write = bus_hs && bus_req_i.wen;
    assign data_read  = bus_hs && !bus_req_i.wen;
    assign last_read  = data_read && (rd_cnt == num_opix - 1'b1);

    ////////////////////////////////////////////////////////////
    // State machine
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin : stateReg
        if (!nrst) begin
            state_q <= acc_ctrl_pkg::S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_comb begin : nextState
        state_d = state_q;
        case (state_q)
            acc_ctrl_pkg::S_IDLE: begin
                if (start_i) state_d = acc_ctrl_pkg::S_LOADWEIGHTS;
            end
            acc_ctrl_pkg::S_LOADWEIGHTS: begin
                if (data_write && wt_ptr == acc_cfg_pkg::WT_IDX_W'(acc_cfg_pkg::WEIGHT_WORDS - 1))
                    state_d = acc_ctrl_pkg::S_LOADSHIFT;
            end
            acc_ctrl_pkg::S_LOADSHIFT: begin
                if (data_write) state_d = acc_ctrl_pkg::S_LOADACTS;
            end
            acc_ctrl_pkg::S_LOADACTS: begin
                if (data_write && wr_ptr + acc_cfg_pkg::ADDR_W'(4) == map_size)
                    state_d = acc_ctrl_pkg::S_COMPUTE;
            end
            acc_ctrl_pkg::S_COMPUTE: begin
                if (mac_out_valid_i && wb_cnt == num_opix - 1'b1)
                    state_d = acc_ctrl_pkg::S_READACTS;
            end
            acc_ctrl_pkg::S_READACTS: begin
                if (last_read) state_d = acc_ctrl_pkg::S_IDLE;
            end
            default: state_d = acc_ctrl_pkg::S_IDLE;
        endcase
        if (clear_i) state_d = acc_ctrl_pkg::S_IDLE;
    end

    ////////////////////////////////////////////////////////////
    // Pointers
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin : loadPointers
        if (!nrst) begin
            wt_ptr <= '0;
            wr_ptr <= '0;
        end else if (clear_i || state_q == acc_ctrl_pkg::S_IDLE) begin
            wt_ptr <= '0;
            wr_ptr <= '0;
        end else begin
            if (state_q == acc_ctrl_pkg::S_LOADWEIGHTS && data_write) wt_ptr <= wt_ptr + 1'b1;
            // Input map words land at byte address 4k
            if (state_q == acc_ctrl_pkg::S_LOADACTS && data_write)
                wr_ptr <= wr_ptr + acc_cfg_pkg::ADDR_W'(4);
        end
    end

    // One row read per cycle, filter row fastest, then x, then y
    assign issue    = (state_q == acc_ctrl_pkg::S_COMPUTE) && !issue_done;
    assign row_base = (acc_cfg_pkg::ADDR_W'(oy) + acc_cfg_pkg::ADDR_W'(fy))
                    * acc_cfg_pkg::ADDR_W'(cfg_i.ifmap_dimx);
    assign row_addr = row_base + acc_cfg_pkg::ADDR_W'(ox);

    always_ff @(posedge clk or negedge nrst) begin : windowWalk
        if (!nrst) begin
            fy         <= '0;
            ox         <= '0;
            oy         <= '0;
            issue_done <= 1'b0;
        end else if (clear_i || state_q != acc_ctrl_pkg::S_COMPUTE) begin
            fy         <= '0;
            ox         <= '0;
            oy         <= '0;
            issue_done <= 1'b0;
        end else if (issue) begin
            if (fy != 2'(acc_cfg_pkg::FILT_Y - 1)) begin
                fy <= fy + 1'b1;
            end else begin
                fy <= '0;
                if (acc_cfg_pkg::DIM_W'(ox) != out_dimx - 1'b1) begin
                    ox <= ox + 1'b1;
                end else begin
                    ox <= '0;
                    if (acc_cfg_pkg::DIM_W'(oy) != out_dimy - 1'b1) oy <= oy + 1'b1;
                    else issue_done <= 1'b1;
                end
            end
        end
    end

    // Output words follow the input map in the buffer
    assign wb_addr = map_size + {wb_cnt, 2'b00};
    assign rd_addr = map_size + {rd_cnt, 2'b00};

    always_ff @(posedge clk or negedge nrst) begin : resultTrack
        if (!nrst) begin
            wb_cnt   <= '0;
            rd_cnt   <= '0;
            row_q    <= '0;
            rvalid_q <= 1'b0;
            done_q   <= 1'b0;
        end else begin
            // Row strobe lines up with the buffer read data
            row_q    <= '{row_valid: issue && !clear_i,
                          row_last:  fy == 2'(acc_cfg_pkg::FILT_Y - 1),
                          row_sel:   fy};
            rvalid_q <= data_read;
            done_q   <= last_read && !clear_i;
            if (clear_i || state_q != acc_ctrl_pkg::S_COMPUTE) wb_cnt <= '0;
            else if (mac_out_valid_i) wb_cnt <= wb_cnt + 1'b1;
            if (clear_i || state_q != acc_ctrl_pkg::S_READACTS) rd_cnt <= '0;
            else if (data_read) rd_cnt <= rd_cnt + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////
    // Strobe decode
    ////////////////////////////////////////////////////////////

    always_comb begin : strobeDecode
        buf_o      = '0;
        mac_load_o = '0;
        case (state_q)
            acc_ctrl_pkg::S_LOADWEIGHTS: begin
                mac_load_o.wt_wr_en = data_write;
                mac_load_o.wt_index = wt_ptr;
                mac_load_o.data     = bus_req_i.wdata;
            end
            acc_ctrl_pkg::S_LOADSHIFT: begin
                mac_load_o.shift_wr_en = data_write;
                mac_load_o.data        = bus_req_i.wdata;
            end
            acc_ctrl_pkg::S_LOADACTS: begin
                buf_o.wr_en   = data_write;
                buf_o.wr_addr = wr_ptr;
                buf_o.wr_data = bus_req_i.wdata;
            end
            acc_ctrl_pkg::S_COMPUTE: begin
                buf_o.rd_en   = issue;
                buf_o.rd_addr = row_addr;
                buf_o.wr_en   = mac_out_valid_i;
                buf_o.wr_addr = wb_addr;
                buf_o.wr_data = mac_out_word_i;
            end
            acc_ctrl_pkg::S_READACTS: begin
                buf_o.rd_en   = data_read;
                buf_o.rd_addr = rd_addr;
            end
            default: ;
        endcase
    end

    assign busy_o    = (state_q != acc_ctrl_pkg::S_IDLE);
    assign done_o    = done_q;
    assign bus_rsp_o = '{rvalid: rvalid_q, rdata: buf_rd_data_i};
    assign row_o     = row_q;

endmodule

`default_nettype wire

/* source/acc_top.sv */
////////////////////////////////////////////////////////////
// Accelerator top: controller, activation buffer, MAC array
////////////////////////////////////////////////////////////
`default_nettype none

module acc_top (
    input  logic                  clk,
    input  logic                  nrst,
    input  acc_cfg_pkg::acc_cfg_t cfg_i,
    input  logic                  start_i,
    input  logic                  clear_i,
    input  acc_cfg_pkg::bus_req_t bus_req_i,
    output logic                  bus_ready_o,
    output acc_cfg_pkg::bus_rsp_t bus_rsp_o,
    output logic                  busy_o,
    output logic                  done_o
);

    acc_ctrl_pkg::buf_ctrl_t       buf_ctrl;
    logic [acc_cfg_pkg::BUS_W-1:0] buf_rd_data;
    acc_ctrl_pkg::mac_load_t       mac_load;
    acc_ctrl_pkg::row_strobe_t     row_strobe;
    logic                          mac_out_valid;
    logic [acc_cfg_pkg::BUS_W-1:0] mac_out_word;

    acc_controller acc_controller_inst (
        .clk             (clk),
        .nrst            (nrst),
        .cfg_i           (cfg_i),
        .start_i         (start_i),
        .clear_i         (clear_i),
        .bus_req_i       (bus_req_i),
        .bus_ready_o     (bus_ready_o),
        .bus_rsp_o       (bus_rsp_o),
        .busy_o          (busy_o),
        .done_o          (done_o),
        .buf_o           (buf_ctrl),
        .buf_rd_data_i   (buf_rd_data),
        .mac_load_o      (mac_load),
        .row_o           (row_strobe),
        .mac_out_valid_i (mac_out_valid),
        .mac_out_word_i  (mac_out_word)
    );

    act_buffer act_buffer_inst (
        .clk       (clk),
        .nrst      (nrst),
        .buf_i     (buf_ctrl),
        .rd_data_o (buf_rd_data)
    );

    mac_array mac_array_inst (
        .clk         (clk),
        .nrst        (nrst),
        .load_i      (mac_load),
        .row_i       (row_strobe),
        .row_data_i  (buf_rd_data),
        .out_valid_o (mac_out_valid),
        .out_word_o  (mac_out_word)
    );

endmodule

`default_nettype wire

/* bench/acc_props.sv */
////////////////////////////////////////////////////////////
// Host bus and run control protocol checks, bound to acc_top
////////////////////////////////////////////////////////////
`default_nettype none

module acc_props (
    input logic                  clk,
    input logic                  nrst,
    input acc_cfg_pkg::bus_req_t bus_req_i,
    input logic                  bus_ready_i,
    input acc_cfg_pkg::bus_rsp_t bus_rsp_i,
    input logic                  busy_i,
    input logic                  done_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // Read by the testbench at the end of the run
    int   fail_cnt = 0;
    logic rd_accept;

    assign rd_accept = bus_req_i.valid && bus_ready_i && !bus_req_i.wen;

    // Read data comes exactly one cycle after an accepted read
    rvalid_needs_read: assert property (@(posedge clk) disable iff (!nrst)
        bus_rsp_i.rvalid |-> $past(rd_accept))
        else begin
            $error("bus_rsp_o.rvalid without an accepted read");
            fail_cnt++;
        end

    read_gives_rvalid: assert property (@(posedge clk) disable iff (!nrst)
        rd_accept |=> bus_rsp_i.rvalid)
        else begin
            $error("accepted read returned no bus_rsp_o.rvalid");
            fail_cnt++;
        end

    done_single_cycle: assert property (@(posedge clk) disable iff (!nrst)
        done_i |-> !busy_i ##1 !done_i)
        else begin
            $error("done_o longer than one cycle or busy_o still high");
            fail_cnt++;
        end

    no_ready_in_idle: assert property (@(posedge clk) disable iff (!nrst)
        !busy_i |-> !bus_ready_i)
        else begin
            $error("bus_ready_o high while idle");
            fail_cnt++;
        end

    // Outputs quiet while reset is held
    quiet_in_reset: assert property (@(posedge clk)
        !nrst |-> !busy_i && !done_i && !bus_ready_i && !bus_rsp_i.rvalid)
        else begin
            $error("outputs active during reset");
            fail_cnt++;
        end

endmodule

bind acc_top acc_props acc_props_inst (
    .clk         (clk),
    .nrst        (nrst),
    .bus_req_i   (bus_req_i),
    .bus_ready_i (bus_ready_o),
    .bus_rsp_i   (bus_rsp_o),
    .busy_i      (busy_o),
    .done_i      (done_o)
);

`default_nettype wire

/* bench/acc_tb.sv */
////////////////////////////////////////////////////////////
// Testbench for acc_top: host bus runs checked against a
// reference 3x3 convolution over four channels
////////////////////////////////////////////////////////////
`default_nettype none

module acc_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 20000;

    logic                  clk;
    logic                  nrst;
    acc_cfg_pkg::acc_cfg_t cfg;
    logic                  start_i;
    logic                  clear_i;
    acc_cfg_pkg::bus_req_t bus_req;
    logic                  bus_ready;
    acc_cfg_pkg::bus_rsp_t bus_rsp;
    logic                  busy;
    logic                  done;

    // Stimulus data and the reference model state
    integer            seed = 32'hd2a2;
    logic [7:0]        pix_mem [256];
    logic signed [7:0] wts [36];
    logic [2:0]        shifts [4];
    int                gap_max = 2;
    int                err_cnt = 0;
    int                pass_tests = 0;
    int                fail_tests = 0;
    int                done_seen = 0;
    int                cycles = 0;
    int                bad;

    acc_top acc_top_inst (
        .clk         (clk),
        .nrst        (nrst),
        .cfg_i       (cfg),
        .start_i     (start_i),
        .clear_i     (clear_i),
        .bus_req_i   (bus_req),
        .bus_ready_o (bus_ready),
        .bus_rsp_o   (bus_rsp),
        .busy_o      (busy),
        .done_o      (done)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        if (done) done_seen <= done_seen + 1;
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run exceeded %0d cycles without finishing", MAX_CYCLES);
            $display("TEST FAIL");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////
    // Host bus and reference model
    ////////////////////////////////////////////////////////////

    // Random idle gap, then hold valid until the handshake edge
    task automatic bus_transfer(input logic wen, input logic [31:0] wdata);
        int   gap;
        logic accepted;
        gap = int'($unsigned($random(seed)) % (gap_max + 1));
        repeat (gap) begin
            @(posedge clk);
            #2;
        end
        bus_req  = '{valid: 1'b1, wen: wen, wdata: wdata};
        accepted = 1'b0;
        while (!accepted) begin
            #1;
            accepted = bus_ready;
            @(posedge clk);
            #2;
        end
        bus_req.valid = 1'b0;
    endtask

    function automatic logic [31:0] expected_word(input int dimx, input int ox, input int oy);
        int          sum;
        int          shifted;
        logic [31:0] word;
        word = '0;
        for (int c = 0; c < 4; c++) begin
            sum = 0;
            for (int r = 0; r < 3; r++) begin
                for (int x = 0; x < 3; x++) begin
                    sum += int'(pix_mem[(oy + r) * dimx + ox + x]) * int'(wts[c * 9 + r * 3 + x]);
                end
            end
            shifted = sum >>> shifts[c];
            if (shifted < 0) word[8*c +: 8] = 8'h00;
            else if (shifted > 255) word[8*c +: 8] = 8'hff;
            else word[8*c +: 8] = 8'(shifted);
        end
        return word;
    endfunction

    task automatic randomize_data(input int n_pix);
        for (int i = 0; i < n_pix; i++) pix_mem[i] = 8'($random(seed));
        for (int i = 0; i < 36; i++) wts[i] = 8'($random(seed));
        for (int c = 0; c < 4; c++) shifts[c] = 3'($random(seed));
    endtask

    task automatic load_run(input int dimx, input int dimy);
        cfg     = '{ifmap_dimx: 5'(dimx), ifmap_dimy: 5'(dimy)};
        start_i = 1'b1;
        @(posedge clk);
        #2;
        start_i = 1'b0;
        for (int w = 0; w < 9; w++) begin
            bus_transfer(1'b1, {wts[4*w+3], wts[4*w+2], wts[4*w+1], wts[4*w]});
        end
        bus_transfer(1'b1, {5'b0, shifts[3], 5'b0, shifts[2], 5'b0, shifts[1],
                            5'b0, shifts[0]});
        for (int k = 0; k < dimx * dimy / 4; k++) begin
            bus_transfer(1'b1, {pix_mem[4*k+3], pix_mem[4*k+2], pix_mem[4*k+1], pix_mem[4*k]});
        end
    endtask

    // Output pixels come back in raster order
    task automatic read_outputs(input int dimx, input int dimy, input logic use_fixed,
                                input logic [31:0] fixed_word, output int n_bad);
        logic [31:0] exp;
        n_bad = 0;
        for (int oy = 0; oy < dimy - 2; oy++) begin
            for (int ox = 0; ox < dimx - 2; ox++) begin
                exp = use_fixed ? fixed_word : expected_word(dimx, ox, oy);
                bus_transfer(1'b0, '0);
                assert (bus_rsp.rvalid) else begin
                    $display("Read at pixel %0d,%0d accepted but no read data came", ox, oy);
                    n_bad++;
                end
                assert (bus_rsp.rdata == exp) else begin
                    $display("CHECK FAILED bus_rsp_o.rdata expected %h actual %h", exp,
                             bus_rsp.rdata);
                    n_bad++;
                end
            end
        end
    endtask

    task automatic run_conv(input string name, input int dimx, input int dimy,
                            input logic use_fixed, input logic [31:0] fixed_word);
        int snap;
        int n_bad;
        int n;
        snap = done_seen;
        load_run(dimx, dimy);
        read_outputs(dimx, dimy, use_fixed, fixed_word, n_bad);
        n = 0;
        while (done_seen == snap && n < 8) begin
            @(posedge clk);
            #2;
            n++;
        end
        repeat (2) @(posedge clk);
        #2;
        assert (done_seen == snap + 1) else begin
            $display("done_o pulsed %0d times instead of once", done_seen - snap);
            n_bad++;
        end
        assert (!busy) else begin
            $display("busy_o still high after the run finished");
            n_bad++;
        end
        report(name, n_bad);
    endtask

    task automatic report(input string name, input int n_bad);
        err_cnt += n_bad;
        if (n_bad == 0) begin
            pass_tests++;
            $display("%s: passed", name);
        end else begin
            fail_tests++;
            $display("%s: failed with %0d errors", name, n_bad);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////////////////////////

    initial begin
        clk     = 1'b0;
        nrst    = 1'b0;
        cfg     = '0;
        start_i = 1'b0;
        clear_i = 1'b0;
        bus_req = '0;
        repeat (8) @(posedge clk);
        #2;
        nrst = 1'b1;

        // Idle outputs, and bus requests are refused while idle
        bad = 0;
        assert (!busy && !done && !bus_ready && !bus_rsp.rvalid) else begin
            $display("Outputs not all low after reset");
            bad++;
        end
        for (int i = 0; i < 6; i++) begin
            bus_req = '{valid: 1'b1, wen: 1'(i), wdata: 32'(i)};
            #1;
            assert (!bus_ready) else begin
                $display("Bus request accepted while idle");
                bad++;
            end
            @(posedge clk);
            #2;
            assert (!bus_rsp.rvalid) else begin
                $display("Read data returned while idle");
                bad++;
            end
        end
        bus_req = '0;
        report("reset and idle", bad);

        randomize_data(36);
        run_conv("6x6 random run", 6, 6, 1'b0, '0);

        clear_i = 1'b1;
        @(posedge clk);
        #2;
        clear_i = 1'b0;
        randomize_data(32);
        run_conv("8x4 run after clear", 8, 4, 1'b0, '0);

        // Fresh data back to back without idle gaps
        gap_max = 0;
        randomize_data(32);
        run_conv("8x4 run without gaps", 8, 4, 1'b0, '0);
        gap_max = 2;

        // Even channels saturate high, odd channels clamp to zero
        for (int i = 0; i < 16; i++) pix_mem[i] = 8'($random(seed)) | 8'h40;
        for (int i = 0; i < 36; i++) wts[i] = ((i / 9) % 2 == 0) ? 8'sd127 : -8'sd128;
        for (int c = 0; c < 4; c++) shifts[c] = 3'd0;
        run_conv("4x4 clamp lanes", 4, 4, 1'b1, 32'h00ff00ff);

        // Abort a run mid compute, then a full run
        bad = 0;
        randomize_data(64);
        load_run(8, 8);
        repeat (5) @(posedge clk);
        #2;
        assert (busy) else begin
            $display("busy_o low before clear_i, compute never started");
            bad++;
        end
        clear_i = 1'b1;
        @(posedge clk);
        #2;
        clear_i = 1'b0;
        assert (!busy) else begin
            $display("busy_o stayed high after clear_i in compute");
            bad++;
        end
        report("clear during compute", bad);
        randomize_data(96);
        run_conv("12x8 run after abort", 12, 8, 1'b0, '0);

        $display("tests passed %0d, failed %0d, protocol errors %0d", pass_tests, fail_tests,
                 acc_top_inst.acc_props_inst.fail_cnt);
        if (fail_tests == 0 && err_cnt == 0 && acc_top_inst.acc_props_inst.fail_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* compile.f */
source/acc_cfg_pkg.sv
source/acc_ctrl_pkg.sv
source/act_buffer.sv
source/mac_array.sv
source/acc_controller.sv
source/acc_top.sv
bench/acc_props.sv
bench/acc_tb.sv
